// File: hw/vec_alu_pkg.sv
package vec_alu_pkg;

  // ----------------------------------------
  // datapath geometry
  // ----------------------------------------
  localparam int DLEN_W   = 128;
  localparam int LANE_W   = 64;
  localparam int N_LANES  = DLEN_W / LANE_W;
  localparam int ELEM_MAX = LANE_W / 8;    // ew8 elements in one lane
  localparam int XLEN_W   = 64;            // scalar rs1 width
  localparam int VL_W     = 8;             // vl runs 0..128
  localparam int RNID_W   = 6;

  // element width, encoded as vsew
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } sew_t;

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_MSEQ = 4'd6,
    OP_MSNE = 4'd7,
    OP_MSLT = 4'd8
  } alu_op_t;

  // ----------------------------------------
  // instruction fields
  // ----------------------------------------
  localparam logic [5:0] F6_ADD  = 6'b000000;
  localparam logic [5:0] F6_SUB  = 6'b000010;
  localparam logic [5:0] F6_AND  = 6'b001001;
  localparam logic [5:0] F6_OR   = 6'b001010;
  localparam logic [5:0] F6_XOR  = 6'b001011;
  localparam logic [5:0] F6_MSEQ = 6'b011000;
  localparam logic [5:0] F6_MSNE = 6'b011001;
  localparam logic [5:0] F6_MSLT = 6'b011011;

  localparam logic [2:0] FUNCT3_OPIVV = 3'b000;  // vector-vector
  localparam logic [2:0] FUNCT3_OPIVX = 3'b100;  // vector-scalar

  // issue packet, operands already read
  typedef struct packed {
    logic              valid;
    logic [31:0]       inst;
    logic [VL_W-1:0]   vl;
    sew_t              vsew;
    logic [DLEN_W-1:0] vs1;
    logic [DLEN_W-1:0] vs2;
    logic [XLEN_W-1:0] rs1;
    logic [DLEN_W-1:0] old;     // old vd contents
    logic [RNID_W-1:0] wr_rnid;
  } issue_t;

  // ex1 stage register
  typedef struct packed {
    logic              valid;
    alu_op_t           op;
    logic              is_mask;   // compare, result goes to a mask
    logic [VL_W-1:0]   vl;
    sew_t              vsew;
    logic [DLEN_W-1:0] vs1;       // rs1 copied to every lane on vx form
    logic              is_scalar;
    logic [DLEN_W-1:0] vs2;
    logic [DLEN_W-1:0] old;
    logic [RNID_W-1:0] wr_rnid;
  } ex1_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rnid;
    logic [DLEN_W-1:0] data;
  } wr_t;

endpackage

// File: hw/vec_alu_decode.sv
`timescale 1ns/100ps

module vec_alu_decode (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  vec_alu_pkg::issue_t i_issue,
  output vec_alu_pkg::ex1_t   o_ex1
);

  logic [5:0]           w_funct6;
  logic [2:0]           w_funct3;
  logic                 w_form_ok;
  vec_alu_pkg::alu_op_t w_op;
  vec_alu_pkg::ex1_t    w_ex1_next;
  vec_alu_pkg::ex1_t    r_ex1;
  logic                 r_ex1_valid;

  assign w_funct6  = i_issue.inst[31:26];
  assign w_funct3  = i_issue.inst[14:12];
  assign w_form_ok = (w_funct3 == vec_alu_pkg::FUNCT3_OPIVV) |
                     (w_funct3 == vec_alu_pkg::FUNCT3_OPIVX);

  // ----------------------------------------
  // ex0 decode
  // ----------------------------------------
  always_comb begin
    case (w_funct6)
      vec_alu_pkg::F6_ADD  : w_op = vec_alu_pkg::OP_ADD;
      vec_alu_pkg::F6_SUB  : w_op = vec_alu_pkg::OP_SUB;
      vec_alu_pkg::F6_AND  : w_op = vec_alu_pkg::OP_AND;
      vec_alu_pkg::F6_OR   : w_op = vec_alu_pkg::OP_OR;
      vec_alu_pkg::F6_XOR  : w_op = vec_alu_pkg::OP_XOR;
      vec_alu_pkg::F6_MSEQ : w_op = vec_alu_pkg::OP_MSEQ;
      vec_alu_pkg::F6_MSNE : w_op = vec_alu_pkg::OP_MSNE;
      vec_alu_pkg::F6_MSLT : w_op = vec_alu_pkg::OP_MSLT;
      default              : w_op = vec_alu_pkg::OP_NOP;
    endcase
    if (!w_form_ok) w_op = vec_alu_pkg::OP_NOP;  // ivi, mvv etc. not handled
  end

  always_comb begin
    w_ex1_next.valid     = i_issue.valid;
    w_ex1_next.op        = w_op;
    w_ex1_next.is_mask   = (w_op == vec_alu_pkg::OP_MSEQ) |
                           (w_op == vec_alu_pkg::OP_MSNE) |
                           (w_op == vec_alu_pkg::OP_MSLT);
    w_ex1_next.vl        = i_issue.vl;
    w_ex1_next.vsew      = i_issue.vsew;
    w_ex1_next.is_scalar = (w_funct3 == vec_alu_pkg::FUNCT3_OPIVX);
    // one operand for the lanes, scalar repeated per lane
    w_ex1_next.vs1       = w_ex1_next.is_scalar ? {vec_alu_pkg::N_LANES{i_issue.rs1}} :
                                                  i_issue.vs1;
    w_ex1_next.vs2       = i_issue.vs2;
    w_ex1_next.old       = i_issue.old;
    w_ex1_next.wr_rnid   = i_issue.wr_rnid;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1 <= w_ex1_next;  // payload, free running
  end

  always_comb begin
    o_ex1       = r_ex1;
    o_ex1.valid = r_ex1_valid;
  end

endmodule

// File: hw/vec_alu_lane.sv
`timescale 1ns/100ps

module vec_alu_lane #(
  parameter int LANE_IDX = 0
) (
  input  vec_alu_pkg::ex1_t                  i_ex1,
  output logic [vec_alu_pkg::LANE_W-1:0]     o_res,
  output logic [vec_alu_pkg::ELEM_MAX-1:0]   o_mask
);

  localparam int LW   = vec_alu_pkg::LANE_W;
  localparam int BASE = LANE_IDX * LW;   // bit offset of this lane

  logic [LW-1:0] w_vs1;
  logic [LW-1:0] w_vs2;
  logic [LW-1:0] w_old;

  assign w_vs1 = i_ex1.vs1[BASE +: LW];
  assign w_vs2 = i_ex1.vs2[BASE +: LW];
  assign w_old = i_ex1.old[BASE +: LW];

  // sign extend the low 'bits' of v to the full lane width
  function automatic logic [LW-1:0] sext(input logic [LW-1:0] v, input int unsigned bits);
    logic [LW-1:0] t;
    t    = v << (LW - bits);
    sext = $signed(t) >>> (LW - bits);
  endfunction

  // ----------------------------------------
  // per element datapath
  // ----------------------------------------
  always_comb begin
    int unsigned   bits;
    int unsigned   n_elem;
    int unsigned   sh;
    int unsigned   g_idx;
    logic [LW-1:0] a;
    logic [LW-1:0] b;
    logic [LW-1:0] r;
    logic [LW-1:0] m;
    logic          en;
    logic          c;

    bits   = 8 << i_ex1.vsew;
    n_elem = vec_alu_pkg::ELEM_MAX >> i_ex1.vsew;
    o_res  = w_old;  // tail undisturbed by default
    o_mask = '0;

    for (int e = 0; e < vec_alu_pkg::ELEM_MAX; e++) begin
      if (e < n_elem) begin
        sh    = e * bits;
        g_idx = LANE_IDX * n_elem + e;   // element index across DLEN
        en    = (g_idx < i_ex1.vl) & (i_ex1.op != vec_alu_pkg::OP_NOP);

        a = sext(w_vs2 >> sh, bits);
        b = i_ex1.is_scalar ? sext(w_vs1, bits) :   // low bits of rs1
                              sext(w_vs1 >> sh, bits);

        case (i_ex1.op)
          vec_alu_pkg::OP_ADD : r = a + b;
          vec_alu_pkg::OP_SUB : r = a - b;          // vs2 - vs1
          vec_alu_pkg::OP_AND : r = a & b;
          vec_alu_pkg::OP_OR  : r = a | b;
          vec_alu_pkg::OP_XOR : r = a ^ b;
          default             : r = a;
        endcase

        // operands are sign extended, so a full width compare is exact
        case (i_ex1.op)
          vec_alu_pkg::OP_MSEQ : c = (a == b);
          vec_alu_pkg::OP_MSNE : c = (a != b);
          vec_alu_pkg::OP_MSLT : c = ($signed(a) < $signed(b));
          default              : c = 1'b0;
        endcase

        if (en) begin
          m     = ({LW{1'b1}} >> (LW - bits)) << sh;
          o_res = (o_res & ~m) | ((r << sh) & m);
        end
        o_mask[e] = en ? c : i_ex1.old[g_idx];   // old mask bit when off
      end
    end
  end

endmodule

// File: hw/vec_alu_writeback.sv
`timescale 1ns/100ps

module vec_alu_writeback (
  input  logic                                                       i_clk,
  input  logic                                                       i_reset_n,
  input  vec_alu_pkg::ex1_t                                          i_ex1,
  input  logic [vec_alu_pkg::N_LANES-1:0][vec_alu_pkg::LANE_W-1:0]   i_lane_res,
  input  logic [vec_alu_pkg::N_LANES-1:0][vec_alu_pkg::ELEM_MAX-1:0] i_lane_mask,
  output vec_alu_pkg::wr_t                                           o_wr
);

  logic [vec_alu_pkg::DLEN_W-1:0] w_mask_data;
  logic [vec_alu_pkg::DLEN_W-1:0] w_data;

  logic                           r_valid;
  logic [vec_alu_pkg::RNID_W-1:0] r_rnid;
  logic [vec_alu_pkg::DLEN_W-1:0] r_data;

  // ----------------------------------------
  // mask packing
  // ----------------------------------------
  always_comb begin
    int unsigned n_elem;

    n_elem      = vec_alu_pkg::ELEM_MAX >> i_ex1.vsew;   // 8/4/2/1 per lane
    w_mask_data = i_ex1.old;   // upper bits keep the old mask
    for (int l = 0; l < vec_alu_pkg::N_LANES; l++) begin
      for (int k = 0; k < vec_alu_pkg::ELEM_MAX; k++) begin
        if (k < n_elem) w_mask_data[l * n_elem + k] = i_lane_mask[l][k];
      end
    end
  end

  assign w_data = i_ex1.is_mask ? w_mask_data : i_lane_res;

  // ----------------------------------------
  // ex2 write record
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_ex1.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rnid <= i_ex1.wr_rnid;
    r_data <= w_data;
  end

  always_comb begin
    o_wr.valid = r_valid;
    o_wr.rnid  = r_rnid;
    o_wr.data  = r_data;
  end

endmodule

// File: hw/vec_alu_pipe.sv
`timescale 1ns/100ps

module vec_alu_pipe (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  vec_alu_pkg::issue_t i_issue,
  output vec_alu_pkg::wr_t    o_wr
);

  vec_alu_pkg::ex1_t w_ex1;

  logic [vec_alu_pkg::N_LANES-1:0][vec_alu_pkg::LANE_W-1:0]   w_lane_res;
  logic [vec_alu_pkg::N_LANES-1:0][vec_alu_pkg::ELEM_MAX-1:0] w_lane_mask;

  // ----------------------------------------
  // ex0 -> ex1
  // ----------------------------------------
  vec_alu_decode u_decode (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (i_issue),
    .o_ex1     (w_ex1)
  );

  // one 64-bit lane per slice of DLEN
  for (genvar l = 0; l < vec_alu_pkg::N_LANES; l++) begin : g_lane
    vec_alu_lane #(
      .LANE_IDX (l)
    ) u_lane (
      .i_ex1  (w_ex1),
      .o_res  (w_lane_res[l]),
      .o_mask (w_lane_mask[l])
    );
  end

  // ----------------------------------------
  // ex1 -> ex2
  // ----------------------------------------
  vec_alu_writeback u_writeback (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_ex1       (w_ex1),
    .i_lane_res  (w_lane_res),
    .i_lane_mask (w_lane_mask),
    .o_wr        (o_wr)
  );

endmodule

// File: test/tb_vec_alu_pipe.sv
`timescale 1ns/100ps

module tb_vec_alu_pipe;

  localparam int RESET_CYC = 2;
  // add sub and or xor followed by mseq msne mslt
  localparam logic [5:0] F6_LIST [8] = '{6'b000000, 6'b000010, 6'b001001, 6'b001010,
                                         6'b001011, 6'b011000, 6'b011001, 6'b011011};

  logic                i_clk;
  logic                i_reset_n;
  vec_alu_pkg::issue_t i_issue;
  vec_alu_pkg::wr_t    o_wr;

  vec_alu_pkg::issue_t tab_issue[$];   // stimulus table
  vec_alu_pkg::wr_t    tab_exp[$];     // expected write for each row
  vec_alu_pkg::wr_t    exp_q[$];       // writes in flight
  int                  due_q[$];       // cycle each write is due
  logic [31:0]         rng = 32'h4fca2189;
  int                  cyc = 0;
  int                  limit = 0;
  int                  checks = 0;
  int                  errors = 0;

  vec_alu_pipe u_vec_alu_pipe (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (i_issue),
    .o_wr      (o_wr)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cyc = cyc + 1;
    if (cyc > limit) begin
      $display("timeout after %0d cycles, %0d writes never arrived", limit, exp_q.size());
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);   // xorshift32
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [127:0] rand_vec();
    logic [127:0] v;
    for (int k = 0; k < 4; k++) v[k*32 +: 32] = next_rand();
    return v;
  endfunction

  // ----------------------------------------
  // reference model working element by element over DLEN
  // ----------------------------------------
  function automatic vec_alu_pkg::wr_t model(input vec_alu_pkg::issue_t is);
    vec_alu_pkg::wr_t w;
    logic [5:0]       f6;
    logic [2:0]       f3;
    logic [127:0]     t;
    logic [63:0]      ones;
    logic [63:0]      sb;
    logic [63:0]      a;
    logic [63:0]      b;
    logic [63:0]      r;
    logic             c;
    int               ew;
    int               kind;   // 0 none, 1 arith, 2 compare

    f6      = is.inst[31:26];
    f3      = is.inst[14:12];
    ew      = 8 << is.vsew;
    ones    = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    sb      = 64'd1 << (ew - 1);
    w.valid = is.valid;
    w.rnid  = is.wr_rnid;
    w.data  = is.old;   // tail and upper mask bits stay old
    if (f3 != 3'b000 && f3 != 3'b100) return w;
    for (int i = 0; i < 128 / ew; i++) begin
      if (i < is.vl) begin
        t    = is.vs2 >> (i * ew);
        a    = t[63:0] & ones;
        t    = is.vs1 >> (i * ew);
        b    = (f3 == 3'b100) ? (is.rs1 & ones) : (t[63:0] & ones);
        r    = '0;
        c    = 1'b0;
        kind = (f6[4:3] == 2'b11) ? 2 : 1;
        case (f6)
          6'b000000 : r = a + b;
          6'b000010 : r = a - b;               // vs2 minus vs1
          6'b001001 : r = a & b;
          6'b001010 : r = a | b;
          6'b001011 : r = a ^ b;
          6'b011000 : c = (a == b);
          6'b011001 : c = (a != b);
          6'b011011 : c = ((a ^ sb) < (b ^ sb));  // sign flip before the unsigned compare
          default   : kind = 0;
        endcase
        if (kind == 2) w.data[i] = c;
        if (kind == 1) for (int k = 0; k < ew; k++) w.data[i*ew + k] = r[k];
      end
    end
    return w;
  endfunction

  // ----------------------------------------
  // table building
  // ----------------------------------------
  task automatic add_row(input logic [5:0] f6, input logic [2:0] f3, input int sew,
                         input int vl, input logic [127:0] vs1, input logic [127:0] vs2,
                         input logic [63:0] rs1, input logic [127:0] old);
    vec_alu_pkg::issue_t is;
    int                  row;
    row        = tab_issue.size();
    is.valid   = 1'b1;
    is.inst    = {f6, 1'b1, 5'd8, 5'd4, f3, 5'd2, 7'b1010111};   // vd v2, vs2 v8, vs1 v4
    is.vl      = vl[7:0];
    is.vsew    = vec_alu_pkg::sew_t'(sew[1:0]);
    is.vs1     = vs1;
    is.vs2     = vs2;
    is.rs1     = rs1;
    is.old     = old;
    is.wr_rnid = row[vec_alu_pkg::RNID_W-1:0];
    tab_issue.push_back(is);
    tab_exp.push_back(model(is));
  endtask

  task automatic add_idle();
    tab_issue.push_back('0);
    tab_exp.push_back('0);
  endtask

  // hand worked result for the last row
  task automatic set_expected(input logic [127:0] data);
    vec_alu_pkg::wr_t w;
    w      = tab_exp.pop_back();
    w.data = data;
    tab_exp.push_back(w);
  endtask

  task automatic build_table();
    logic [127:0] v;
    logic [31:0]  r;

    add_idle();
    for (int s = 0; s < 4; s++) begin
      for (int k = 0; k < 5; k++) add_row(F6_LIST[k], 3'b000, s, 128, rand_vec(), rand_vec(),
                                          64'h0, rand_vec());
    end
    add_row(F6_LIST[0], 3'b000, 0, 128, {16{8'h01}}, {16{8'hff}}, 64'h0, rand_vec());
    set_expected('0);                                    // byte wrap
    add_row(F6_LIST[1], 3'b000, 1, 128, {8{16'h0001}}, '0, 64'h0, rand_vec());
    set_expected('1);
    add_row(F6_LIST[0], 3'b000, 2, 128, {4{32'h1}}, {4{32'h7fffffff}}, 64'h0, rand_vec());
    set_expected({4{32'h80000000}});
    add_row(F6_LIST[1], 3'b000, 3, 128, {2{64'h1}}, {2{64'h8000_0000_0000_0000}}, 64'h0, '0);
    set_expected({2{64'h7fff_ffff_ffff_ffff}});
    // tail undisturbed rows where vl 11 splits lane 1
    add_row(F6_LIST[0], 3'b000, 0, 0, rand_vec(), rand_vec(), 64'h0, rand_vec());
    add_row(F6_LIST[4], 3'b000, 0, 11, rand_vec(), rand_vec(), 64'h0, rand_vec());
    add_row(F6_LIST[1], 3'b000, 1, 5, rand_vec(), rand_vec(), 64'h0, rand_vec());
    add_row(F6_LIST[3], 3'b000, 3, 1, rand_vec(), rand_vec(), 64'h0, rand_vec());
    add_row(F6_LIST[0], 3'b000, 2, 3, {4{32'h1}}, {4{32'h10}}, 64'h0, {4{32'hdeadbeef}});
    set_expected({32'hdeadbeef, {3{32'h11}}});
    add_idle();
    // scalar form
    for (int s = 0; s < 4; s++) add_row(F6_LIST[0], 3'b100, s, 128, rand_vec(), rand_vec(),
                                        {next_rand(), next_rand()}, rand_vec());
    add_row(F6_LIST[4], 3'b100, 1, 6, rand_vec(), rand_vec(), {next_rand(), next_rand()},
            rand_vec());
    add_row(F6_LIST[0], 3'b100, 1, 8, rand_vec(), '0, 64'hffff_ffff_ffff_0003, rand_vec());
    set_expected({8{16'h0003}});
    // compares with vs1 close to vs2 so some elements match
    for (int s = 0; s < 4; s++) begin
      for (int k = 5; k < 8; k++) begin
        v = rand_vec();
        add_row(F6_LIST[k], 3'b000, s, 128, v ^ (rand_vec() & rand_vec() & rand_vec()), v,
                64'h0, rand_vec());
      end
    end
    add_row(F6_LIST[7], 3'b000, 0, 5, rand_vec(), rand_vec(), 64'h0, rand_vec());
    v = rand_vec();
    add_row(F6_LIST[5], 3'b000, 3, 1, v, v, 64'h0, rand_vec());
    add_row(F6_LIST[6], 3'b100, 1, 128, rand_vec(), rand_vec(), {next_rand(), next_rand()},
            rand_vec());
    add_row(F6_LIST[7], 3'b000, 2, 128, '0, {32'h80000000, 32'h7fffffff, 32'hffffffff, 32'h1},
            64'h0, '1);
    set_expected({{124{1'b1}}, 4'b1010});
    v = rand_vec();
    add_row(6'b111111, 3'b000, 0, 128, rand_vec(), rand_vec(), 64'h0, v);
    set_expected(v);                                     // unknown funct6
    // back to back random flow
    for (int n = 0; n < 16; n++) begin
      r = next_rand();
      add_row(F6_LIST[r[2:0]], r[3] ? 3'b100 : 3'b000, r[5:4], r[7] ? 128 : r[12:8],
              rand_vec(), rand_vec(), {next_rand(), next_rand()}, rand_vec());
    end
  endtask

  // ----------------------------------------
  // output checking on each falling edge
  // ----------------------------------------
  task automatic check_output();
    vec_alu_pkg::wr_t want;
    int               due;

    if (o_wr.valid === 1'b1) begin
      assert (exp_q.size() > 0) else begin
        $display("extra write at %0t: rnid %0d with no issue behind it", $time, o_wr.rnid);
        errors++;
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        due  = due_q.pop_front();
        checks++;
        assert (cyc == due) else begin
          $display("write for rnid %0d came at cycle %0d instead of %0d", want.rnid, cyc, due);
          errors++;
        end
        assert (o_wr.rnid === want.rnid) else begin
          $display("[FAIL] %0t o_wr.rnid expected %0d actual %0d", $time, want.rnid, o_wr.rnid);
          errors++;
        end
        assert (o_wr.data === want.data) else begin
          $display("[FAIL] %0t o_wr.data expected %h actual %h", $time, want.data, o_wr.data);
          errors++;
        end
      end
    end else begin
      assert (o_wr.valid === 1'b0) else begin
        $display("[FAIL] %0t o_wr.valid expected 0 actual %b", $time, o_wr.valid);
        errors++;
      end
      assert (!(due_q.size() > 0 && due_q[0] <= cyc)) else begin
        $display("missing write: rnid %0d due at cycle %0d never came", exp_q[0].rnid, due_q[0]);
        errors++;
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  endtask

  initial begin
    i_reset_n = 1'b0;
    i_issue   = '0;
    build_table();
    limit = RESET_CYC + tab_issue.size() + 20;
    repeat (RESET_CYC) begin
      @(negedge i_clk);
      check_output();
    end
    i_reset_n = 1'b1;
    foreach (tab_issue[i]) begin
      check_output();
      i_issue = tab_issue[i];
      if (tab_issue[i].valid) begin
        exp_q.push_back(tab_exp[i]);
        due_q.push_back(cyc + 2);   // decode reg and then writeback reg
      end
      @(negedge i_clk);
    end
    i_issue = '0;
    while (exp_q.size() > 0) begin
      check_output();
      @(negedge i_clk);
    end
    repeat (2) begin
      @(negedge i_clk);
      check_output();   // nothing may trail the last write
    end
    $display("writes checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
hw/vec_alu_pkg.sv
hw/vec_alu_decode.sv
hw/vec_alu_lane.sv
hw/vec_alu_writeback.sv
hw/vec_alu_pipe.sv
test/tb_vec_alu_pipe.sv

// File: Bender.yml
package:
  name: vec_alu_pipe

sources:
  - files:
      - hw/vec_alu_pkg.sv
      - hw/vec_alu_decode.sv
      - hw/vec_alu_lane.sv
      - hw/vec_alu_writeback.sv
      - hw/vec_alu_pipe.sv
  - target: test
    files:
      - test/tb_vec_alu_pipe.sv
